/* include/dec_defs.svh */
`ifndef DEC_DEFS_SVH
`define DEC_DEFS_SVH

// Datapath and PC width
`define XLEN 32

// Instruction width, compressed forms not supported
`define ILEN 32

`define REGSEL_BITS 5
`define NUM_REGS 32

// Up to 3 outstanding writes per register
`define PEND_BITS 2

`endif

/* design/dec_pkg.sv */
`include "dec_defs.svh"

package dec_pkg;

    typedef logic [`XLEN-1:0]        xlen_t;
    typedef logic [`REGSEL_BITS-1:0] regsel_t;
    typedef logic [`PEND_BITS-1:0]   pend_t;
    typedef logic [`ILEN-1:0]        inst_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_CMP_LT, ALU_CMP_LTU, ALU_XOR,
        ALU_OR, ALU_AND, ALU_SH_L, ALU_SH_RL, ALU_SH_RA
    } alu_op_e;

    typedef enum logic [2:0] {
        BROP_NEVER, BROP_ALWAYS, BROP_EQ, BROP_NE,
        BROP_LT, BROP_GE, BROP_LTU, BROP_GEU
    } br_op_e;

    typedef enum logic [1:0] {MEMOP_NONE, MEMOP_LOAD, MEMOP_STORE} mem_op_e;
    typedef enum logic [1:0] {MEMSZ_1B, MEMSZ_2B, MEMSZ_4B} mem_sz_e;

    // Major opcode, inst[6:2]
    typedef enum logic [4:0] {
        RV_LOAD   = 5'b00000,
        RV_OP_IMM = 5'b00100,
        RV_AUIPC  = 5'b00101,
        RV_STORE  = 5'b01000,
        RV_OP     = 5'b01100,
        RV_LUI    = 5'b01101,
        RV_BRANCH = 5'b11000,
        RV_JALR   = 5'b11001,
        RV_JAL    = 5'b11011
    } rv_op_e;

    typedef enum logic [0:0] {ISSUE_OPEN, ISSUE_WAIT_JMP} issue_state_e;

    typedef struct packed {
        xlen_t   arg1;
        xlen_t   arg2;
        regsel_t dst;
        br_op_e  br_op;
        alu_op_e alu_op;
        mem_op_e mem_op;
        mem_sz_e size;
        logic    is_signed; // Loads only
        xlen_t   payload;
        xlen_t   payload2;
    } issue_pkt_t;

    typedef struct packed {
        regsel_t rs1;
        regsel_t rs2;
        regsel_t rd;
        logic    uses_rs1;
        logic    uses_rs2;
        logic    uses_rd;
    } reg_use_t;

    typedef struct packed {
        logic    valid;
        regsel_t rd;
        xlen_t   val;
    } wb_t;

endpackage

/* design/inst_decoder.sv */
`timescale 1ns/10ps

module inst_decoder import dec_pkg::*; (
    input  inst_t      inst,
    input  xlen_t      inst_pc,
    input  xlen_t      rs1_data,
    input  xlen_t      rs2_data,
    output reg_use_t   reg_use,
    output logic       op_valid,
    output logic       is_jump,
    output issue_pkt_t alu_pkt
);

    rv_op_e     op;
    logic [2:0] func3;
    logic [6:0] func7;
    logic       inv;    // SUB or arithmetic shift
    logic       ext;    // Immediate sign
    logic       len_ok; // 32-bit encoding
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;

    assign op     = rv_op_e'(inst[6:2]);
    assign func3  = inst[14:12];
    assign func7  = inst[31:25];
    assign inv    = func7[5];
    assign ext    = inst[31];
    assign len_ok = (inst[1:0] == 2'b11);

    assign imm_i = {{21{ext}}, inst[30:20]};
    assign imm_s = {{21{ext}}, inst[30:25], inst[11:7]};
    assign imm_b = {{20{ext}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{ext}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // Shared by OP and OP-IMM
    function automatic alu_op_e f3_alu(input logic [2:0] f3, input logic alt,
                                       input logic reg_op);
        alu_op_e res;
        case (f3)
            3'b000:  res = (alt && reg_op) ? ALU_SUB : ALU_ADD; // No SUBI
            3'b001:  res = ALU_SH_L;
            3'b010:  res = ALU_CMP_LT;
            3'b011:  res = ALU_CMP_LTU;
            3'b100:  res = ALU_XOR;
            3'b101:  res = alt ? ALU_SH_RA : ALU_SH_RL;
            3'b110:  res = ALU_OR;
            default: res = ALU_AND;
        endcase
        return res;
    endfunction

    always_comb begin
        op_valid = 1'b0;
        reg_use.rs1      = inst[19:15];
        reg_use.rs2      = inst[24:20];
        reg_use.rd       = inst[11:7];
        reg_use.uses_rs1 = 1'b0;
        reg_use.uses_rs2 = 1'b0;
        reg_use.uses_rd  = 1'b0;
        alu_pkt.arg1      = '0;
        alu_pkt.arg2      = '0;
        alu_pkt.dst       = '0;
        alu_pkt.br_op     = BROP_NEVER;
        alu_pkt.alu_op    = ALU_ADD;
        alu_pkt.mem_op    = MEMOP_NONE;
        alu_pkt.size      = MEMSZ_1B;
        alu_pkt.is_signed = 1'b0;
        alu_pkt.payload   = '0;
        alu_pkt.payload2  = '0;

        case (op)
            RV_OP_IMM: begin
                op_valid = 1'b1;
                alu_pkt.arg1   = rs1_data;
                alu_pkt.arg2   = imm_i;
                alu_pkt.dst    = inst[11:7];
                alu_pkt.alu_op = f3_alu(func3, inv, 1'b0);
                reg_use.uses_rs1 = 1'b1;
                reg_use.uses_rd  = 1'b1;
            end
            RV_OP: begin
                op_valid = (func7[4:0] == 5'b00000) && !func7[6];
                alu_pkt.arg1   = rs1_data;
                alu_pkt.arg2   = rs2_data;
                alu_pkt.dst    = inst[11:7];
                alu_pkt.alu_op = f3_alu(func3, inv, 1'b1);
                reg_use.uses_rs1 = 1'b1;
                reg_use.uses_rs2 = 1'b1;
                reg_use.uses_rd  = 1'b1;
            end
            RV_LUI, RV_AUIPC: begin
                op_valid = 1'b1;
                alu_pkt.arg1 = (op == RV_AUIPC) ? inst_pc : '0;
                alu_pkt.arg2 = imm_u;
                alu_pkt.dst  = inst[11:7];
                reg_use.uses_rd = 1'b1;
            end
            RV_LOAD: begin
                op_valid = (func3 != 3'b011) && (func3[2:1] != 2'b11);
                alu_pkt.arg1      = rs1_data; // Address via ADD
                alu_pkt.arg2      = imm_i;
                alu_pkt.dst       = inst[11:7];
                alu_pkt.mem_op    = MEMOP_LOAD;
                alu_pkt.size      = (func3[1:0] == 2'b00) ? MEMSZ_1B :
                                    (func3[1:0] == 2'b01) ? MEMSZ_2B : MEMSZ_4B;
                alu_pkt.is_signed = !func3[2] && (func3[1:0] != 2'b10); // LB, LH
                reg_use.uses_rs1 = 1'b1;
                reg_use.uses_rd  = 1'b1;
            end
            RV_STORE: begin
                op_valid = !func3[2] && (func3 != 3'b011);
                alu_pkt.arg1    = rs1_data;
                alu_pkt.arg2    = imm_s;
                alu_pkt.mem_op  = MEMOP_STORE;
                alu_pkt.size    = (func3[1:0] == 2'b00) ? MEMSZ_1B :
                                  (func3[1:0] == 2'b01) ? MEMSZ_2B : MEMSZ_4B;
                alu_pkt.payload = rs2_data; // Store data
                reg_use.uses_rs1 = 1'b1;
                reg_use.uses_rs2 = 1'b1;
            end
            RV_JAL, RV_JALR: begin
                op_valid = (op == RV_JAL) || (func3 == 3'b000);
                alu_pkt.arg1    = (op == RV_JAL) ? inst_pc : rs1_data;
                alu_pkt.arg2    = (op == RV_JAL) ? imm_j : imm_i;
                alu_pkt.dst     = inst[11:7];
                alu_pkt.br_op   = BROP_ALWAYS;
                alu_pkt.payload = inst_pc; // Link address base
                reg_use.uses_rs1 = (op == RV_JALR);
                reg_use.uses_rd  = 1'b1;
            end
            RV_BRANCH: begin
                op_valid = (func3[2:1] != 2'b01);
                alu_pkt.arg1     = inst_pc; // Target via ADD
                alu_pkt.arg2     = imm_b;
                alu_pkt.payload  = rs1_data;
                alu_pkt.payload2 = rs2_data;
                case (func3)
                    3'b000:  alu_pkt.br_op = BROP_EQ;
                    3'b001:  alu_pkt.br_op = BROP_NE;
                    3'b100:  alu_pkt.br_op = BROP_LT;
                    3'b101:  alu_pkt.br_op = BROP_GE;
                    3'b110:  alu_pkt.br_op = BROP_LTU;
                    3'b111:  alu_pkt.br_op = BROP_GEU;
                    default: alu_pkt.br_op = BROP_NEVER;
                endcase
                reg_use.uses_rs1 = 1'b1;
                reg_use.uses_rs2 = 1'b1;
            end
            default: op_valid = 1'b0; // SYSTEM, MISC-MEM and the rest
        endcase

        if (!len_ok) begin
            op_valid = 1'b0;
        end
    end

    assign is_jump = (alu_pkt.br_op != BROP_NEVER);

endmodule

/* design/reg_file.sv */
`timescale 1ns/10ps
`include "dec_defs.svh"

module reg_file import dec_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  regsel_t rs1,
    input  regsel_t rs2,
    input  wb_t     wb,
    output xlen_t   rs1_data,
    output xlen_t   rs2_data
);

    // x0 not stored
    xlen_t regs [1:`NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.val;
        end
    end

    assign rs1_data = (rs1 != '0) ? regs[rs1] : '0;
    assign rs2_data = (rs2 != '0) ? regs[rs2] : '0;

endmodule

/* design/write_scoreboard.sv */
`timescale 1ns/10ps
`include "dec_defs.svh"

module write_scoreboard import dec_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_use_t reg_use,
    input  logic     write_issue,
    input  wb_t      wb,
    output logic     hazard
);

    pend_t                pend [`NUM_REGS];
    logic [`NUM_REGS-1:0] inc_vec;
    logic [`NUM_REGS-1:0] dec_vec;
    logic                 rs1_haz;
    logic                 rs2_haz;
    logic                 rd_full;

    always_comb begin
        inc_vec = '0;
        dec_vec = '0;
        if (write_issue) inc_vec[reg_use.rd] = 1'b1; // rd never 0 here
        if (wb.valid && (wb.rd != '0)) dec_vec[wb.rd] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                pend[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                if (inc_vec[i] && !dec_vec[i]) begin
                    pend[i] <= pend[i] + pend_t'(1);
                end else if (dec_vec[i] && !inc_vec[i]) begin
                    pend[i] <= pend[i] - pend_t'(1);
                end
            end
        end
    end

    assign rs1_haz = reg_use.uses_rs1 && (reg_use.rs1 != '0) && (pend[reg_use.rs1] != '0);
    assign rs2_haz = reg_use.uses_rs2 && (reg_use.rs2 != '0) && (pend[reg_use.rs2] != '0);
    assign rd_full = reg_use.uses_rd && (pend[reg_use.rd] == '1); // Counter would wrap

    assign hazard = rs1_haz || rs2_haz || rd_full;

endmodule

/* design/issue_ctrl.sv */
`timescale 1ns/10ps

module issue_ctrl import dec_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic inst_valid,
    input  logic op_valid,
    input  logic is_jump,
    input  logic uses_rd,
    input  logic rd_nonzero,
    input  logic hazard,
    input  logic alu_ready,
    input  logic jmp_done,
    output logic inst_ready,
    output logic alu_valid,
    output logic write_issue
);

    issue_state_e state;
    logic         stall;
    logic         issue;

    assign stall       = hazard || (state == ISSUE_WAIT_JMP);
    assign inst_ready  = alu_ready && !rst && (!inst_valid || !stall);
    assign alu_valid   = inst_valid && op_valid && !stall && !rst;
    assign issue       = alu_valid && alu_ready;
    assign write_issue = issue && uses_rd && rd_nonzero;

    // Hold issue until execute resolves the jump
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ISSUE_OPEN;
        end else begin
            case (state)
                ISSUE_OPEN:     if (issue && is_jump) state <= ISSUE_WAIT_JMP;
                ISSUE_WAIT_JMP: if (jmp_done) state <= ISSUE_OPEN;
                default:        state <= ISSUE_OPEN;
            endcase
        end
    end

endmodule

/* design/rv_decode_stage.sv */
`timescale 1ns/10ps

module rv_decode_stage import dec_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  inst_t      inst,
    input  xlen_t      inst_pc,
    input  logic       inst_valid,
    output logic       inst_ready,
    output logic       alu_valid,
    input  logic       alu_ready,
    output issue_pkt_t alu_pkt,
    input  logic       jmp_done,
    input  wb_t        wb
);

    reg_use_t reg_use;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    logic     op_valid;
    logic     is_jump;
    logic     hazard;
    logic     write_issue;

    inst_decoder i_inst_decoder (
        .inst     (inst),
        .inst_pc  (inst_pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .reg_use  (reg_use),
        .op_valid (op_valid),
        .is_jump  (is_jump),
        .alu_pkt  (alu_pkt)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1      (reg_use.rs1),
        .rs2      (reg_use.rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    write_scoreboard i_write_scoreboard (
        .clk         (clk),
        .rst         (rst),
        .reg_use     (reg_use),
        .write_issue (write_issue),
        .wb          (wb),
        .hazard      (hazard)
    );

    issue_ctrl i_issue_ctrl (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .op_valid    (op_valid),
        .is_jump     (is_jump),
        .uses_rd     (reg_use.uses_rd),
        .rd_nonzero  (reg_use.rd != '0),
        .hazard      (hazard),
        .alu_ready   (alu_ready),
        .jmp_done    (jmp_done),
        .inst_ready  (inst_ready),
        .alu_valid   (alu_valid),
        .write_issue (write_issue)
    );

endmodule

/* dv/decode_chk.sv */
`timescale 1ns/10ps

module decode_chk import dec_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       alu_valid,
    input logic       alu_ready,
    input issue_pkt_t alu_pkt,
    input logic       is_jump,
    input logic       jmp_done
);

    logic jmp_open; // Jump issued, not yet resolved

    always_ff @(posedge clk) begin
        if (rst) begin
            jmp_open <= 1'b0;
        end else if (alu_valid && alu_ready && is_jump) begin
            jmp_open <= 1'b1;
        end else if (jmp_done) begin
            jmp_open <= 1'b0;
        end
    end

    a_no_valid_in_rst: assert property (@(posedge clk) rst |-> !alu_valid)
        else $error("alu_valid high during reset");

    a_pkt_held: assert property (@(posedge clk) disable iff (rst)
        (alu_valid && !alu_ready) |=> $stable(alu_pkt))
        else $error("alu_pkt changed under back-pressure");

    a_no_issue_in_jump: assert property (@(posedge clk) disable iff (rst)
        jmp_open |-> !(alu_valid && alu_ready))
        else $error("issue while a jump is unresolved");

endmodule

bind rv_decode_stage decode_chk i_decode_chk (
    .clk       (clk),
    .rst       (rst),
    .alu_valid (alu_valid),
    .alu_ready (alu_ready),
    .alu_pkt   (alu_pkt),
    .is_jump   (is_jump),
    .jmp_done  (jmp_done)
);

/* dv/tb_decode.sv */
`timescale 1ns/10ps
`include "dec_defs.svh"

module tb_decode import dec_pkg::*; ;

    localparam logic [31:0] SEED = 32'hfc7dfb2f;
    localparam logic [31:0] TAPS = 32'h80200003;
    localparam int NUM_INST = 600;
    localparam int TIMEOUT  = 1000;

    logic       clk;
    logic       rst;
    inst_t      inst;
    xlen_t      inst_pc;
    logic       inst_valid;
    logic       inst_ready;
    logic       alu_valid;
    logic       alu_ready;
    issue_pkt_t alu_pkt;
    logic       jmp_done;
    wb_t        wb;

    xlen_t      mregs [`NUM_REGS];
    int         pend_cnt [`NUM_REGS];
    logic       jmp_wait;
    logic       hold_prev;
    issue_pkt_t held_pkt;
    int         issue_cnt;
    int         jump_cnt;
    int         illegal_cnt;

    rv_decode_stage i_rv_decode_stage (
        .clk        (clk),
        .rst        (rst),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .alu_valid  (alu_valid),
        .alu_ready  (alu_ready),
        .alu_pkt    (alu_pkt),
        .jmp_done   (jmp_done),
        .wb         (wb)
    );

    // Galois LFSR, one step per bit, bits shifted in from the bottom
    function automatic logic [31:0] take_bits(inout logic [31:0] st, input int n);
        logic [31:0] val;
        logic        b;
        val = '0;
        for (int k = 0; k < n; k++) begin
            b = st[0];
            st = st >> 1;
            if (b) st = st ^ TAPS;
            val = {val[30:0], b};
        end
        return val;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [159:0] got,
                         input logic [159:0] exp);
        if (got !== exp) begin
            $display("Fail %s got %h expected %h", name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    function automatic inst_t make_inst(inout logic [31:0] st);
        logic [31:0] sel;
        logic [6:0]  f7;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [4:0]  op5;
        logic [1:0]  low;
        sel = take_bits(st, 4);
        f7  = 7'(take_bits(st, 7));
        rs2 = {2'b00, 3'(take_bits(st, 3))}; // Few registers, more hazards
        rs1 = {2'b00, 3'(take_bits(st, 3))};
        rd  = {2'b00, 3'(take_bits(st, 3))};
        f3  = 3'(take_bits(st, 3));
        low = 2'b11;
        case (sel)
            0, 1:    op5 = RV_OP_IMM;
            2, 3: begin
                op5 = RV_OP;
                if (take_bits(st, 3) != 0) f7 = {1'b0, f7[5], 5'b0};
            end
            4:       op5 = RV_LUI;
            5:       op5 = RV_AUIPC;
            6, 7:    op5 = RV_LOAD;
            8, 9:    op5 = RV_STORE;
            10:      op5 = RV_JAL;
            11:      op5 = RV_JALR;
            12, 13:  op5 = RV_BRANCH;
            14:      op5 = 5'b11100; // SYSTEM
            default: begin
                op5 = 5'(take_bits(st, 5));
                low = 2'(take_bits(st, 2));
            end
        endcase
        return {f7, rs2, rs1, f3, rd, op5, low};
    endfunction

    function automatic mem_sz_e size_of(input logic [1:0] f);
        if (f == 2'b00) return MEMSZ_1B;
        if (f == 2'b01) return MEMSZ_2B;
        return MEMSZ_4B;
    endfunction

    // Expected packet from the RV32I encoding rules
    function automatic issue_pkt_t ref_decode(input inst_t i, input xlen_t pc,
            input xlen_t r1, input xlen_t r2, output logic legal,
            output logic u1, output logic u2, output logic wr);
        issue_pkt_t p;
        logic [2:0] f3;
        xlen_t      imm_i;
        xlen_t      imm_s;
        xlen_t      imm_b;
        xlen_t      imm_u;
        xlen_t      imm_j;
        f3    = i[14:12];
        imm_i = {{20{i[31]}}, i[31:20]};
        imm_s = {{20{i[31]}}, i[31:25], i[11:7]};
        imm_b = {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
        imm_u = {i[31:12], 12'h000};
        imm_j = {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
        p = '0;
        p.br_op = BROP_NEVER;
        legal = 1'b0;
        u1 = 1'b0;
        u2 = 1'b0;
        wr = 1'b0;
        case (i[6:2])
            RV_OP_IMM, RV_OP: begin
                u1 = 1'b1;
                wr = 1'b1;
                p.arg1 = r1;
                p.dst  = i[11:7];
                if (i[6:2] == RV_OP) begin
                    legal = (i[31:25] == 7'h00) || (i[31:25] == 7'h20);
                    u2 = 1'b1;
                    p.arg2 = r2;
                end else begin
                    legal = 1'b1;
                    p.arg2 = imm_i;
                end
                case (f3)
                    3'd0: p.alu_op = (i[6:2] == RV_OP && i[30]) ? ALU_SUB : ALU_ADD;
                    3'd1: p.alu_op = ALU_SH_L;
                    3'd2: p.alu_op = ALU_CMP_LT;
                    3'd3: p.alu_op = ALU_CMP_LTU;
                    3'd4: p.alu_op = ALU_XOR;
                    3'd5: p.alu_op = i[30] ? ALU_SH_RA : ALU_SH_RL;
                    3'd6: p.alu_op = ALU_OR;
                    default: p.alu_op = ALU_AND;
                endcase
            end
            RV_LUI, RV_AUIPC: begin
                legal = 1'b1;
                wr = 1'b1;
                p.arg1 = (i[6:2] == RV_AUIPC) ? pc : '0;
                p.arg2 = imm_u;
                p.dst  = i[11:7];
            end
            RV_LOAD: begin
                legal = (f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd2) ||
                        (f3 == 3'd4) || (f3 == 3'd5);
                u1 = 1'b1;
                wr = 1'b1;
                p.arg1 = r1;
                p.arg2 = imm_i;
                p.dst  = i[11:7];
                p.mem_op = MEMOP_LOAD;
                p.size = size_of(f3[1:0]);
                p.is_signed = (f3 == 3'd0) || (f3 == 3'd1);
            end
            RV_STORE: begin
                legal = (f3 <= 3'd2);
                u1 = 1'b1;
                u2 = 1'b1;
                p.arg1 = r1;
                p.arg2 = imm_s;
                p.mem_op = MEMOP_STORE;
                p.size = size_of(f3[1:0]);
                p.payload = r2;
            end
            RV_JAL, RV_JALR: begin
                legal = (i[6:2] == RV_JAL) || (f3 == 3'd0);
                u1 = (i[6:2] == RV_JALR);
                wr = 1'b1;
                p.arg1 = (i[6:2] == RV_JAL) ? pc : r1;
                p.arg2 = (i[6:2] == RV_JAL) ? imm_j : imm_i;
                p.dst  = i[11:7];
                p.br_op = BROP_ALWAYS;
                p.payload = pc;
            end
            RV_BRANCH: begin
                legal = (f3 != 3'd2) && (f3 != 3'd3);
                u1 = 1'b1;
                u2 = 1'b1;
                p.arg1 = pc;
                p.arg2 = imm_b;
                p.payload  = r1;
                p.payload2 = r2;
                case (f3)
                    3'd0: p.br_op = BROP_EQ;
                    3'd1: p.br_op = BROP_NE;
                    3'd4: p.br_op = BROP_LT;
                    3'd5: p.br_op = BROP_GE;
                    3'd6: p.br_op = BROP_LTU;
                    3'd7: p.br_op = BROP_GEU;
                    default: p.br_op = BROP_NEVER;
                endcase
            end
            default: legal = 1'b0;
        endcase
        if (i[1:0] != 2'b11) legal = 1'b0;
        return p;
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Execute and writeback model
    initial begin
        logic [31:0] ex_st;
        wb_t         wb_q[$];
        int          wb_gap;
        int          jmp_cnt;
        alu_ready = 1'b1;
        jmp_done  = 1'b0;
        wb        = '0;
        ex_st     = SEED;
        void'(take_bits(ex_st, 999)); // Decorrelate from stimulus
        wb_gap    = 0;
        jmp_cnt   = 0;
        forever begin
            @(posedge clk);
            if (rst) begin
                alu_ready <= 1'b1; // Only rst holds the stage here
                jmp_done  <= 1'b0;
                wb        <= '0;
                wb_q.delete();
                wb_gap  = 0;
                jmp_cnt = 0;
            end else begin
                jmp_done <= 1'b0;
                if (jmp_cnt != 0) begin
                    jmp_cnt--;
                    if (jmp_cnt == 0) jmp_done <= 1'b1;
                end
                if (alu_valid && alu_ready) begin
                    if (alu_pkt.dst != '0) begin
                        wb_q.push_back({1'b1, alu_pkt.dst, take_bits(ex_st, 32)});
                    end
                    if (alu_pkt.br_op != BROP_NEVER) jmp_cnt = take_bits(ex_st, 4) + 1;
                end
                if (wb_q.size() != 0 && wb_gap == 0) begin
                    wb <= wb_q.pop_front();
                    wb_gap = take_bits(ex_st, 3);
                end else begin
                    wb.valid <= 1'b0;
                    if (wb_gap != 0) wb_gap--;
                end
                alu_ready <= (take_bits(ex_st, 3) != 0);
            end
        end
    end

    // Comparator, owns the model register file and pending counts
    always @(posedge clk) begin
        issue_pkt_t exp_pkt;
        logic       legal;
        logic       u1;
        logic       u2;
        logic       wr;
        logic       src_busy;
        if (rst) begin
            check("inst_ready", 160'(inst_ready), 160'(1'b0));
            check("alu_valid", 160'(alu_valid), 160'(1'b0));
            for (int k = 0; k < `NUM_REGS; k++) begin
                mregs[k] = '0;
                pend_cnt[k] = 0;
            end
            jmp_wait = 1'b0;
            hold_prev = 1'b0;
        end else begin
            if (!alu_ready) check("inst_ready", 160'(inst_ready), 160'(1'b0));
            if (hold_prev && alu_valid) check("alu_pkt", 160'(alu_pkt), 160'(held_pkt));
            hold_prev = alu_valid && !alu_ready;
            held_pkt  = alu_pkt;
            exp_pkt = ref_decode(inst, inst_pc, mregs[inst[19:15]], mregs[inst[24:20]],
                                 legal, u1, u2, wr);
            src_busy = (u1 && inst[19:15] != 0 && pend_cnt[inst[19:15]] != 0) ||
                       (u2 && inst[24:20] != 0 && pend_cnt[inst[24:20]] != 0);
            if (inst_valid && !legal) begin
                check("alu_valid", 160'(alu_valid), 160'(1'b0));
                if (inst_ready) illegal_cnt++;
            end
            // A consumed legal instruction issues in the same cycle
            if (inst_valid && inst_ready && legal) begin
                check("alu_valid", 160'(alu_valid), 160'(1'b1));
            end
            if ((inst_valid && inst_ready) || (alu_valid && alu_ready)) begin
                if (jmp_wait) abort_run("Instruction taken before the jump was resolved");
                if (src_busy) begin
                    abort_run("Instruction taken before its source register was written back");
                end
            end
            if (alu_valid && alu_ready) begin
                check("alu_pkt", 160'(alu_pkt), 160'(exp_pkt));
                issue_cnt++;
                if (wr && inst[11:7] != 0) pend_cnt[inst[11:7]]++;
                if (exp_pkt.br_op != BROP_NEVER) begin
                    jmp_wait = 1'b1;
                    jump_cnt++;
                end
            end
            if (jmp_done) jmp_wait = 1'b0;
            if (wb.valid && wb.rd != '0) begin
                mregs[wb.rd] = wb.val;
                pend_cnt[wb.rd]--;
            end
        end
    end

    // Stimulus
    initial begin
        logic [31:0] st;
        int          cycles;
        st          = SEED;
        rst         = 1'b1;
        inst        = 32'h0000_0013; // ADDI x0, x0, 0 offered during reset
        inst_pc     = 32'h0000_1000;
        inst_valid  = 1'b1;
        issue_cnt   = 0;
        jump_cnt    = 0;
        illegal_cnt = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < NUM_INST; n++) begin
            if (take_bits(st, 3) == 0) begin
                inst_valid <= 1'b0; // Fetch bubble
                @(posedge clk);
            end
            inst       <= make_inst(st);
            inst_pc    <= 32'h0000_1000 + 32'(n * 4);
            inst_valid <= 1'b1;
            cycles = 0;
            do begin
                @(posedge clk);
                cycles++;
                if (cycles > TIMEOUT) abort_run("Timed out waiting for inst_ready");
            end while (!inst_ready);
        end
        inst_valid <= 1'b0;
        repeat (40) @(posedge clk);
        if (jump_cnt == 0) begin
            abort_run("No jump or branch was issued");
        end else if (illegal_cnt == 0) begin
            abort_run("No illegal instruction was consumed");
        end else if (issue_cnt <= NUM_INST / 2) begin
            abort_run("Fewer than half of the instructions were issued");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

/* build.f */
+incdir+include
design/dec_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/write_scoreboard.sv
design/issue_ctrl.sv
design/rv_decode_stage.sv
dv/decode_chk.sv
dv/tb_decode.sv

/* Makefile */
SIM      ?= verilator
TOP      ?= tb_decode
FLIST    ?= build.f
OBJ_DIR  ?= obj_dir
VFLAGS   ?= --binary --timing
PASS_MSG ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove build products"
	@echo "  help   list the targets"

test:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
